/* build.f */
+incdir+.
ddr_nt_pkg.sv
ddr_nt_sequencer.sv
ddr_nt_lane_ctrl.sv
ddr_nt_regf_ptr.sv
ddr_nt_stall_ctrl.sv
ddr_nt_top.sv
tb_ddr_nt.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing -f build.f --top-module tb_ddr_nt -o tb_ddr_nt \
	&& ./obj_dir/tb_ddr_nt \
	|| { echo "run_sim: build or simulation returned an error"; exit 1; }

/* tb_ddr_nt_tasks.svh */
`ifndef TB_DDR_NT_TASKS_SVH
`define TB_DDR_NT_TASKS_SVH

task automatic check_eq(input string name, input logic [31:0] actual,
	input logic [31:0] expected);
	if (actual !== expected)
	begin
		$display("FAIL %s: got 0x%0h expected 0x%0h", name, actual, expected);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first mismatch");
	end
endtask

function automatic ddr_nt_pkg::xfer_cfg_t make_cfg(input logic toc, input logic [4:0] dev,
	input logic short_err, input logic rnw, input logic imm);
	ddr_nt_pkg::xfer_cfg_t c;
	c.toc            = toc;
	c.dev_index      = dev;
	c.short_read_err = short_err;
	c.rnw            = rnw;
	c.immediate      = imm;
	c.wroc           = 1'b0;
	return c;
endfunction

task automatic push_resp(input logic pre, input logic err, input logic last);
	resp_t r;
	r.rx_pre   = pre;
	r.rx_error = err;
	r.frm_last = last;
	resp_q.push_back(r);
endtask

// n phases with all status bits low
task automatic push_plain(input int n);
	repeat (n) push_resp(1'b0, 1'b0, 1'b0);
endtask

// one frame from engine_en to the done pulse, then the phase count
task automatic run_frame(input ddr_nt_pkg::xfer_cfg_t c, input int n_pulses);
	cfg = c;
	rec_q.delete();
	stall_seen = 1'b0;
	stall_cyc  = 5'd0;
	done_cnt   = 0;
	engine_en  = 1'b1;
	@(posedge sys_clk);
	#1;
	engine_en = 1'b0;
	while (!engine_done)
	begin
		@(posedge sys_clk);
		#1;
	end
	repeat (3)
	begin
		@(posedge sys_clk);	// room for a stray second pulse
		#1;
	end
	check_eq("o_engine_done pulses", 32'(done_cnt), 32'd1);
	check_eq("lane done pulses", 32'(rec_q.size()), 32'(n_pulses));
	check_eq("unused lane answers", 32'(resp_q.size()), 32'd0);
endtask

task automatic reset_values();
	check_eq("o_lane.tx_en", 32'(lane_cmd.tx_en), 32'd0);
	check_eq("o_lane.rx_en", 32'(lane_cmd.rx_en), 32'd0);
	check_eq("o_regf_wr_en", 32'(regf_wr_en), 32'd0);
	check_eq("o_regf_rd_en", 32'(regf_rd_en), 32'd0);
	check_eq("o_stall.en", 32'(stall.en), 32'd0);
	check_eq("o_engine_done", 32'(engine_done), 32'd0);
	check_eq("o_regf_error_type", 32'(regf_err), 32'(ddr_nt_pkg::err_success));
endtask

task automatic write_one_word();
	logic [3:0] exp_tx [0:13];
	logic [3:0] got [$];
	exp_tx = '{ddr_nt_pkg::txm_special_pre, ddr_nt_pkg::txm_zero_pre,
		ddr_nt_pkg::txm_seven_zeros, ddr_nt_pkg::txm_address, ddr_nt_pkg::txm_parity,
		ddr_nt_pkg::txm_one_pre, ddr_nt_pkg::txm_byte, ddr_nt_pkg::txm_byte,
		ddr_nt_pkg::txm_parity, ddr_nt_pkg::txm_zero_pre, ddr_nt_pkg::txm_one_pre,
		ddr_nt_pkg::txm_token_crc, ddr_nt_pkg::txm_crc_value, ddr_nt_pkg::txm_restart};
	push_plain(9);	// command, ack and both bytes
	push_resp(1'b0, 1'b0, 1'b1);	// data parity on the last word
	push_plain(5);
	bitcnt = 6'd11;	// crc value near its end
	run_frame(make_cfg(1'b0, 5'd3, 1'b0, 1'b0, 1'b0), 15);
	bitcnt = 6'd0;
	foreach (rec_q[i])
	begin
		if (rec_q[i].is_tx)
			got.push_back(rec_q[i].mode);
		check_eq("o_regf_error_type", 32'(rec_q[i].err), 32'(ddr_nt_pkg::err_success));
	end
	check_eq("tx mode count", 32'(got.size()), 32'd14);
	foreach (exp_tx[i])
		check_eq("o_lane.tx_mode", 32'(got[i]), 32'(exp_tx[i]));
	check_eq("o_lane.special_data", 32'(rec_q[3].spec), 32'(DYN_BASE) + 32'd3);
	check_eq("o_regf_rd_en", 32'(rec_q[6].rd_en), 32'd1);	// prefetch on ack
	check_eq("o_regf_addr", 32'(rec_q[7].addr), 32'(WR_BASE));
	check_eq("o_regf_rd_en", 32'(rec_q[7].rd_en), 32'd1);
	check_eq("o_regf_wr_en", 32'(rec_q[7].wr_en), 32'd0);
	check_eq("o_regf_addr", 32'(rec_q[8].addr), 32'(WR_BASE) + 32'd1);
	check_eq("o_stall.en", 32'(rec_q[12].stall_en), 32'd0);
	check_eq("o_stall.en", 32'(rec_q[13].stall_en), 32'd1);	// crc end of a write
	check_eq("o_stall.en", 32'(stall_seen), 32'd1);
	check_eq("o_stall.cycles", 32'(stall_cyc), 32'(RST_STALL));
endtask

task automatic nack_then_exit();
	push_plain(6);
	push_resp(1'b1, 1'b0, 1'b0);	// target leaves the ack bit high
	push_plain(2);	// error settle, exit pattern
	run_frame(make_cfg(1'b1, 5'd1, 1'b0, 1'b0, 1'b0), 9);
	check_eq("ack phase is_tx", 32'(rec_q[6].is_tx), 32'd0);
	check_eq("o_regf_error_type", 32'(rec_q[6].err), 32'(ddr_nt_pkg::err_nack));
	check_eq("o_regf_rd_en", 32'(rec_q[6].rd_en), 32'd0);
	check_eq("o_lane.rx_mode", 32'(rec_q[7].mode), 32'(ddr_nt_pkg::rxm_error));
	check_eq("o_bitcnt_rst", 32'(rec_q[7].bitcnt_rst), 32'd1);
	check_eq("o_lane.tx_mode", 32'(rec_q[8].mode), 32'(ddr_nt_pkg::txm_exit));
	check_eq("o_stall.cycles", 32'(stall_cyc), 32'(EXT_STALL));
endtask

task automatic read_bad_crc();
	push_plain(10);	// up to the data parity, no parity fault
	push_resp(1'b0, 1'b0, 1'b1);	// data preamble ends the read
	push_resp(1'b1, 1'b0, 1'b0);	// crc preamble from the target
	push_plain(1);
	push_resp(1'b0, 1'b1, 1'b0);	// crc value mismatch
	push_plain(2);
	bitcnt = 6'd11;
	run_frame(make_cfg(1'b0, 5'd2, 1'b0, 1'b1, 1'b0), 16);
	bitcnt = 6'd0;
	check_eq("o_lane.tx_mode", 32'(rec_q[1].mode), 32'(ddr_nt_pkg::txm_one_pre));
	check_eq("o_lane.rx_mode", 32'(rec_q[7].mode), 32'(ddr_nt_pkg::rxm_byte));
	check_eq("o_regf_addr", 32'(rec_q[7].addr), 32'(RD_BASE));
	check_eq("o_regf_wr_en", 32'(rec_q[7].wr_en), 32'd1);
	check_eq("o_regf_rd_en", 32'(rec_q[7].rd_en), 32'd0);
	check_eq("o_regf_wr_en", 32'(rec_q[8].wr_en), 32'd1);
	check_eq("o_regf_addr", 32'(rec_q[8].addr), 32'(RD_BASE) + 32'd1);
	check_eq("o_regf_error_type", 32'(rec_q[12].err), 32'(ddr_nt_pkg::err_success));
	check_eq("o_lane.rx_mode", 32'(rec_q[13].mode), 32'(ddr_nt_pkg::rxm_check_crc));
	check_eq("o_regf_error_type", 32'(rec_q[13].err), 32'(ddr_nt_pkg::err_crc));
	check_eq("o_stall.en", 32'(rec_q[13].stall_en), 32'd0);	// no stall on a bad crc
	check_eq("o_lane.rx_mode", 32'(rec_q[14].mode), 32'(ddr_nt_pkg::rxm_error));
	check_eq("o_bitcnt_rst", 32'(rec_q[14].bitcnt_rst), 32'd1);
	check_eq("o_lane.tx_mode", 32'(rec_q[15].mode), 32'(ddr_nt_pkg::txm_restart));
endtask

task automatic short_read_stop();
	push_plain(10);
	push_resp(1'b0, 1'b0, 1'b0);	// preamble 0 before the last word
	push_plain(2);
	run_frame(make_cfg(1'b1, 5'd4, 1'b1, 1'b1, 1'b0), 13);
	check_eq("data preamble is_tx", 32'(rec_q[10].is_tx), 32'd0);
	check_eq("o_regf_error_type", 32'(rec_q[10].err), 32'(ddr_nt_pkg::err_short_read));
	check_eq("o_lane.rx_mode", 32'(rec_q[11].mode), 32'(ddr_nt_pkg::rxm_error));
	check_eq("o_lane.tx_mode", 32'(rec_q[12].mode), 32'(ddr_nt_pkg::txm_exit));
endtask

task automatic write_target_abort();
	push_plain(11);	// parity not last, then the data preamble
	push_resp(1'b0, 1'b0, 1'b0);	// target pulls the abort bit low
	push_plain(2);
	run_frame(make_cfg(1'b0, 5'd0, 1'b0, 1'b0, 1'b0), 14);
	check_eq("o_lane.tx_mode", 32'(rec_q[10].mode), 32'(ddr_nt_pkg::txm_one_pre));
	check_eq("o_regf_abort", 32'(rec_q[10].abort), 32'd0);
	check_eq("abort bit is_tx", 32'(rec_q[11].is_tx), 32'd0);
	check_eq("o_regf_abort", 32'(rec_q[11].abort), 32'd1);
	check_eq("o_regf_error_type", 32'(rec_q[11].err), 32'(ddr_nt_pkg::err_bus_aborted));
	check_eq("o_lane.rx_mode", 32'(rec_q[12].mode), 32'(ddr_nt_pkg::rxm_error));
	check_eq("o_lane.tx_mode", 32'(rec_q[13].mode), 32'(ddr_nt_pkg::txm_restart));
	check_eq("o_stall.en", 32'(stall_seen), 32'd1);	// restart stall without a crc window
	check_eq("o_stall.cycles", 32'(stall_cyc), 32'(RST_STALL));
endtask

`endif

/* tb_ddr_nt.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ddr_nt;

	// a frame is at most 16 lane phases of up to 5 cycles, five frames stay far below this
	localparam int TIMEOUT_CYC = 4000;

	localparam logic [7:0]  DYN_BASE  = 8'd8;
	localparam logic [11:0] WR_BASE   = 12'd1;
	localparam logic [11:0] RD_BASE   = 12'd10;
	localparam logic [11:0] IMM_BASE  = 12'd20;
	localparam logic [4:0]  RST_STALL = 5'd10;
	localparam logic [4:0]  EXT_STALL = 5'd16;

	typedef struct packed {
		logic rx_pre;
		logic rx_error;
		logic frm_last;
	} resp_t;

	// outputs seen on one done pulse
	typedef struct packed {
		logic        is_tx;
		logic [3:0]  mode;
		logic [7:0]  spec;
		logic [3:0]  err;
		logic        abort;
		logic        bitcnt_rst;
		logic [11:0] addr;
		logic        wr_en;
		logic        rd_en;
		logic        stall_en;
	} done_rec_t;

	logic                   sys_clk;
	logic                   sys_rst;
	logic                   engine_en;
	ddr_nt_pkg::xfer_cfg_t  cfg;
	ddr_nt_pkg::lane_stat_t lane_stat;
	logic [5:0]             bitcnt;	// bit position from the bit counter
	ddr_nt_pkg::lane_cmd_t  lane_cmd;
	logic                   regf_wr_en;
	logic                   regf_rd_en;
	logic [11:0]            regf_addr;
	logic                   regf_abort;
	ddr_nt_pkg::err_type_e  regf_err;
	logic                   bitcnt_rst;
	ddr_nt_pkg::stall_req_t stall;
	logic                   engine_done;

	resp_t       resp_q [$];	// lane answers, one per done pulse
	done_rec_t   rec_q [$];
	logic        stall_seen;
	logic [4:0]  stall_cyc;
	int          done_cnt;
	int unsigned seed_ret;

	ddr_nt_top #(
		.DYN_ADDR_BASE (DYN_BASE),
		.REGF_WR_BASE  (WR_BASE),
		.REGF_RD_BASE  (RD_BASE),
		.REGF_IMM_BASE (IMM_BASE),
		.RESTART_STALL (RST_STALL),
		.EXIT_STALL    (EXT_STALL)
	) dut_i (
		.i_sys_clk         (sys_clk),
		.i_sys_rst         (sys_rst),
		.i_engine_en       (engine_en),
		.i_cfg             (cfg),
		.i_lane            (lane_stat),
		.i_bitcnt          (bitcnt),
		.o_lane            (lane_cmd),
		.o_regf_wr_en      (regf_wr_en),
		.o_regf_rd_en      (regf_rd_en),
		.o_regf_addr       (regf_addr),
		.o_regf_abort      (regf_abort),
		.o_regf_error_type (regf_err),
		.o_bitcnt_rst      (bitcnt_rst),
		.o_stall           (stall),
		.o_engine_done     (engine_done)
	);

	`include "tb_ddr_nt_tasks.svh"

	initial
	begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;	// 4 ns period
	end

	// serializer and deserializer model, one done per enabled mode
	initial
	begin : lane_responder
		int unsigned wait_cyc;
		resp_t       r;
		seed_ret = $urandom(32'h4ae6);	// seed of the delay generator
		forever
		begin
			@(posedge sys_clk);
			#1;
			if (sys_rst && (lane_cmd.tx_en || lane_cmd.rx_en))
			begin
				wait_cyc = $urandom_range(4, 1);
				repeat (wait_cyc - 1)
				begin
					@(posedge sys_clk);
					#1;
				end
				if (resp_q.size() > 0)
					r = resp_q.pop_front();
				else
					r = '0;	// surplus phase, caught by the count check
				lane_stat.rx_pre   = r.rx_pre;
				lane_stat.rx_error = r.rx_error;
				lane_stat.frm_last = r.frm_last;
				lane_stat.tx_done  = lane_cmd.tx_en;
				lane_stat.rx_done  = !lane_cmd.tx_en;
				@(posedge sys_clk);
				#1;
				lane_stat = '0;
			end
		end
	end

	// sample between edges, inputs and outputs are settled here
	always @(negedge sys_clk)
	begin : snapshot
		done_rec_t rec;
		if (lane_stat.tx_done || lane_stat.rx_done)
		begin
			rec.is_tx = lane_stat.tx_done;
			if (lane_stat.tx_done)
				rec.mode = lane_cmd.tx_mode;
			else
				rec.mode = lane_cmd.rx_mode;
			rec.spec       = lane_cmd.special_data;
			rec.err        = regf_err;
			rec.abort      = regf_abort;
			rec.bitcnt_rst = bitcnt_rst;
			rec.addr       = regf_addr;
			rec.wr_en      = regf_wr_en;
			rec.rd_en      = regf_rd_en;
			rec.stall_en   = stall.en;
			rec_q.push_back(rec);
		end
		if (stall.en)
		begin
			stall_seen = 1'b1;
			stall_cyc  = stall.cycles;
		end
		if (engine_done)
			done_cnt++;
	end

	initial
	begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYC)
		begin
			@(posedge sys_clk);
			cycles++;
		end
		$display("timeout: the tests did not end within %0d clock cycles", TIMEOUT_CYC);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped by the cycle limit");
	end

	initial
	begin : main
		sys_rst    = 1'b0;
		engine_en  = 1'b0;
		cfg        = '0;
		lane_stat  = '0;
		bitcnt     = 6'd0;
		stall_seen = 1'b0;
		stall_cyc  = 5'd0;
		done_cnt   = 0;
		repeat (4) @(posedge sys_clk);
		#1;
		sys_rst = 1'b1;
		reset_values();
		write_one_word();
		nack_then_exit();
		read_bad_crc();
		short_read_stop();
		write_target_abort();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* ddr_nt_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ddr_nt_top #(
	parameter logic [7:0]                    DYN_ADDR_BASE = 8'd8,
	parameter logic [ddr_nt_pkg::ADDR_W-1:0] REGF_WR_BASE  = 1,
	parameter logic [ddr_nt_pkg::ADDR_W-1:0] REGF_RD_BASE  = 10,
	parameter logic [ddr_nt_pkg::ADDR_W-1:0] REGF_IMM_BASE = 20,
	parameter logic [4:0]                    RESTART_STALL = 5'd10,
	parameter logic [4:0]                    EXIT_STALL    = 5'd16
) (
	input  wire                             i_sys_clk,
	input  wire                             i_sys_rst,
	input  wire                             i_engine_en,
	input  ddr_nt_pkg::xfer_cfg_t           i_cfg,	// stable while running
	input  ddr_nt_pkg::lane_stat_t          i_lane,
	input  wire [5:0]                       i_bitcnt,
	output ddr_nt_pkg::lane_cmd_t           o_lane,
	output logic                            o_regf_wr_en,
	output logic                            o_regf_rd_en,
	output logic [ddr_nt_pkg::ADDR_W-1:0]   o_regf_addr,
	output logic                            o_regf_abort,
	output ddr_nt_pkg::err_type_e           o_regf_error_type,
	output logic                            o_bitcnt_rst,
	output ddr_nt_pkg::stall_req_t          o_stall,
	output logic                            o_engine_done
);

	ddr_nt_pkg::nt_state_e state;
	logic                  data_phase;
	logic                  ack_ready;
	logic                  err_branch;

	ddr_nt_sequencer seq_i (
		.i_sys_clk     (i_sys_clk),
		.i_sys_rst     (i_sys_rst),
		.i_engine_en   (i_engine_en),
		.i_cfg         (i_cfg),
		.i_lane        (i_lane),
		.o_state       (state),
		.o_data_phase  (data_phase),
		.o_ack_ready   (ack_ready),
		.o_err_branch  (err_branch),
		.o_engine_done (o_engine_done)
	);

	ddr_nt_lane_ctrl #(
		.DYN_ADDR_BASE (DYN_ADDR_BASE)
	) lane_i (
		.i_state      (state),
		.i_data_phase (data_phase),
		.i_ack_ready  (ack_ready),
		.i_err_branch (err_branch),
		.i_cfg        (i_cfg),
		.i_lane       (i_lane),
		.o_lane       (o_lane),
		.o_error_type (o_regf_error_type),
		.o_abort      (o_regf_abort),
		.o_bitcnt_rst (o_bitcnt_rst)
	);

	ddr_nt_regf_ptr #(
		.REGF_WR_BASE  (REGF_WR_BASE),
		.REGF_RD_BASE  (REGF_RD_BASE),
		.REGF_IMM_BASE (REGF_IMM_BASE)
	) ptr_i (
		.i_sys_clk    (i_sys_clk),
		.i_sys_rst    (i_sys_rst),
		.i_state      (state),
		.i_cfg        (i_cfg),
		.i_lane       (i_lane),
		.o_regf_addr  (o_regf_addr),
		.o_regf_wr_en (o_regf_wr_en),
		.o_regf_rd_en (o_regf_rd_en)
	);

	// scl stall toward the bus timing block
	ddr_nt_stall_ctrl #(
		.RESTART_STALL (RESTART_STALL),
		.EXIT_STALL    (EXIT_STALL)
	) stall_i (
		.i_state  (state),
		.i_cfg    (i_cfg),
		.i_lane   (i_lane),
		.i_bitcnt (i_bitcnt),
		.o_stall  (o_stall)
	);

endmodule

`default_nettype wire

/* ddr_nt_stall_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module ddr_nt_stall_ctrl #(
	parameter logic [4:0] RESTART_STALL = 5'd10,
	parameter logic [4:0] EXIT_STALL    = 5'd16
) (
	input  ddr_nt_pkg::nt_state_e   i_state,
	input  ddr_nt_pkg::xfer_cfg_t   i_cfg,
	input  ddr_nt_pkg::lane_stat_t  i_lane,
	input  wire [5:0]               i_bitcnt,
	output ddr_nt_pkg::stall_req_t  o_stall
);

	logic crc_end;	// last bits of the crc value on the bus

	assign crc_end = (i_bitcnt == 6'd11) || (i_bitcnt == 6'd12);

	always_comb
	begin
		o_stall.en     = 1'b0;
		o_stall.cycles = 5'd0;
		case (i_state)
			ddr_nt_pkg::st_crc_value:
				o_stall.en = crc_end && (!i_cfg.rnw || !i_lane.rx_error);	// no stall on bad crc
			ddr_nt_pkg::st_restart, ddr_nt_pkg::st_exit:
				o_stall.en = !i_lane.tx_done;	// released with the pattern
			default:
				o_stall.en = 1'b0;
		endcase
		if (o_stall.en)
			o_stall.cycles = i_cfg.toc ? EXIT_STALL : RESTART_STALL;
	end

endmodule

`default_nettype wire

/* ddr_nt_regf_ptr.sv */
`timescale 1ns/10ps
`default_nettype none

module ddr_nt_regf_ptr #(
	parameter logic [ddr_nt_pkg::ADDR_W-1:0] REGF_WR_BASE  = 1,
	parameter logic [ddr_nt_pkg::ADDR_W-1:0] REGF_RD_BASE  = 10,
	parameter logic [ddr_nt_pkg::ADDR_W-1:0] REGF_IMM_BASE = 20
) (
	input  wire                                i_sys_clk,
	input  wire                                i_sys_rst,
	input  ddr_nt_pkg::nt_state_e              i_state,
	input  ddr_nt_pkg::xfer_cfg_t              i_cfg,
	input  ddr_nt_pkg::lane_stat_t             i_lane,
	output logic [ddr_nt_pkg::ADDR_W-1:0]      o_regf_addr,
	output logic                               o_regf_wr_en,
	output logic                               o_regf_rd_en
);

	localparam logic [ddr_nt_pkg::ADDR_W-1:0] ADDR_STEP = 1;

	logic ack_ok;	// target acked the command
	logic in_byte;	// a real data byte, dummy excluded

	assign ack_ok  = (i_state == ddr_nt_pkg::st_ack_wait) && i_lane.rx_done && !i_lane.rx_pre;
	assign in_byte = (i_state == ddr_nt_pkg::st_data_byte_1)
		|| (i_state == ddr_nt_pkg::st_data_byte_2);

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
			o_regf_addr <= '0;
		else if (ack_ok)
		begin
			if (i_cfg.rnw)
				o_regf_addr <= REGF_RD_BASE;
			else if (i_cfg.immediate)
				o_regf_addr <= REGF_IMM_BASE;
			else
				o_regf_addr <= REGF_WR_BASE;
		end
		else if (in_byte && (i_lane.tx_done || i_lane.rx_done))
			o_regf_addr <= o_regf_addr + ADDR_STEP;	// next byte slot
	end

	// write bytes come out of the register file, read bytes go in
	assign o_regf_rd_en = !i_cfg.rnw && (in_byte || ack_ok);	// ack_ok prefetches byte 1
	assign o_regf_wr_en = i_cfg.rnw && in_byte;

endmodule

`default_nettype wire

/* ddr_nt_lane_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module ddr_nt_lane_ctrl #(
	parameter logic [7:0] DYN_ADDR_BASE = 8'd8
) (
	input  ddr_nt_pkg::nt_state_e   i_state,
	input  wire                     i_data_phase,
	input  wire                     i_ack_ready,
	input  wire                     i_err_branch,	// sequencer is heading for error
	input  ddr_nt_pkg::xfer_cfg_t   i_cfg,
	input  ddr_nt_pkg::lane_stat_t  i_lane,
	output ddr_nt_pkg::lane_cmd_t   o_lane,
	output ddr_nt_pkg::err_type_e   o_error_type,
	output logic                    o_abort,
	output logic                    o_bitcnt_rst
);

	// tx or rx per state, direction from rnw where the bus turns around
	always_comb
	begin
		o_lane.tx_en        = 1'b0;
		o_lane.tx_mode      = ddr_nt_pkg::txm_special_pre;
		o_lane.rx_en        = 1'b0;
		o_lane.rx_mode      = ddr_nt_pkg::rxm_preamble;
		o_lane.special_data = 8'd0;
		case (i_state)
			ddr_nt_pkg::st_cmd_pre:
				o_lane.tx_en = 1'b1;
			ddr_nt_pkg::st_rw_bit:
			begin
				o_lane.tx_en   = 1'b1;
				o_lane.tx_mode = i_cfg.rnw ? ddr_nt_pkg::txm_one_pre : ddr_nt_pkg::txm_zero_pre;
			end
			ddr_nt_pkg::st_seven_zeros:
			begin
				o_lane.tx_en   = 1'b1;
				o_lane.tx_mode = ddr_nt_pkg::txm_seven_zeros;
			end
			ddr_nt_pkg::st_address:
			begin
				o_lane.tx_en        = 1'b1;
				o_lane.tx_mode      = ddr_nt_pkg::txm_address;
				o_lane.special_data = DYN_ADDR_BASE + {3'b000, i_cfg.dev_index};
			end
			ddr_nt_pkg::st_parity:
			begin
				if (i_cfg.rnw && i_data_phase)
				begin
					o_lane.rx_en   = 1'b1;	// target drives read data parity
					o_lane.rx_mode = ddr_nt_pkg::rxm_check_parity;
				end
				else
				begin
					o_lane.tx_en   = 1'b1;
					o_lane.tx_mode = ddr_nt_pkg::txm_parity;
				end
			end
			ddr_nt_pkg::st_ack_pre:
			begin
				o_lane.tx_en   = 1'b1;
				o_lane.tx_mode = ddr_nt_pkg::txm_one_pre;
			end
			ddr_nt_pkg::st_ack_wait:
				o_lane.rx_en = i_ack_ready;	// one settle cycle first
			ddr_nt_pkg::st_data_byte_1, ddr_nt_pkg::st_data_byte_2, ddr_nt_pkg::st_dummy_byte:
			begin
				o_lane.tx_en   = !i_cfg.rnw;
				o_lane.tx_mode = ddr_nt_pkg::txm_byte;
				o_lane.rx_en   = i_cfg.rnw;
				o_lane.rx_mode = ddr_nt_pkg::rxm_byte;
			end
			ddr_nt_pkg::st_data_pre, ddr_nt_pkg::st_crc_pre_2:
			begin
				o_lane.tx_en   = !i_cfg.rnw;
				o_lane.tx_mode = ddr_nt_pkg::txm_one_pre;
				o_lane.rx_en   = i_cfg.rnw;	// preamble comes from the target
			end
			ddr_nt_pkg::st_abort_bit:
			begin
				o_lane.tx_en   = i_cfg.rnw;	// controller continues or stops the read
				o_lane.tx_mode = i_lane.frm_last ? ddr_nt_pkg::txm_zero_pre
					: ddr_nt_pkg::txm_one_pre;
				o_lane.rx_en   = !i_cfg.rnw;
			end
			ddr_nt_pkg::st_crc_pre_1:
			begin
				o_lane.tx_en   = 1'b1;
				o_lane.tx_mode = ddr_nt_pkg::txm_zero_pre;
			end
			ddr_nt_pkg::st_crc_token:
			begin
				o_lane.tx_en   = !i_cfg.rnw;
				o_lane.tx_mode = ddr_nt_pkg::txm_token_crc;
				o_lane.rx_en   = i_cfg.rnw;
				o_lane.rx_mode = ddr_nt_pkg::rxm_check_token;
			end
			ddr_nt_pkg::st_crc_value:
			begin
				o_lane.tx_en   = !i_cfg.rnw;
				o_lane.tx_mode = ddr_nt_pkg::txm_crc_value;
				o_lane.rx_en   = i_cfg.rnw;
				o_lane.rx_mode = ddr_nt_pkg::rxm_check_crc;
			end
			ddr_nt_pkg::st_error:
			begin
				o_lane.rx_en   = 1'b1;
				o_lane.rx_mode = ddr_nt_pkg::rxm_error;
			end
			ddr_nt_pkg::st_restart:
			begin
				o_lane.tx_en   = 1'b1;
				o_lane.tx_mode = ddr_nt_pkg::txm_restart;
			end
			ddr_nt_pkg::st_exit:
			begin
				o_lane.tx_en   = 1'b1;
				o_lane.tx_mode = ddr_nt_pkg::txm_exit;
			end
			default:
				o_lane.tx_en = 1'b0;	// idle, lanes quiet
		endcase
	end

	// label the branch taken by the sequencer, valid only on the strobe
	always_comb
	begin
		o_error_type = ddr_nt_pkg::err_success;
		o_abort      = 1'b0;
		if (i_err_branch)
		begin
			case (i_state)
				ddr_nt_pkg::st_parity:    o_error_type = ddr_nt_pkg::err_parity;
				ddr_nt_pkg::st_ack_wait:  o_error_type = ddr_nt_pkg::err_nack;
				ddr_nt_pkg::st_data_pre:  o_error_type = ddr_nt_pkg::err_short_read;
				ddr_nt_pkg::st_crc_pre_2: o_error_type = ddr_nt_pkg::err_frame;	// pre 00
				ddr_nt_pkg::st_crc_token: o_error_type = ddr_nt_pkg::err_frame;
				ddr_nt_pkg::st_crc_value: o_error_type = ddr_nt_pkg::err_crc;
				ddr_nt_pkg::st_abort_bit:
				begin
					o_error_type = ddr_nt_pkg::err_bus_aborted;
					o_abort      = !i_cfg.rnw;	// only a target abort of a write
				end
				default:
					o_error_type = ddr_nt_pkg::err_success;
			endcase
		end
	end

	assign o_bitcnt_rst = (i_state == ddr_nt_pkg::st_error);	// restart bit counting

endmodule

`default_nettype wire

/* ddr_nt_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module ddr_nt_sequencer (
	input  wire                     i_sys_clk,
	input  wire                     i_sys_rst,
	input  wire                     i_engine_en,
	input  ddr_nt_pkg::xfer_cfg_t   i_cfg,
	input  ddr_nt_pkg::lane_stat_t  i_lane,
	output ddr_nt_pkg::nt_state_e   o_state,
	output logic                    o_data_phase,	// parity belongs to data, not command
	output logic                    o_ack_ready,
	output logic                    o_err_branch,
	output logic                    o_engine_done
);

	ddr_nt_pkg::nt_state_e state_q;
	ddr_nt_pkg::nt_state_e state_d;
	logic                  step;	// any lane finished its mode

	assign step = i_lane.tx_done | i_lane.rx_done;

	// frame state register
	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
			state_q <= ddr_nt_pkg::st_idle;
		else
			state_q <= state_d;
	end

	always_comb
	begin
		state_d = state_q;	// hold until the lane reports done
		case (state_q)
			ddr_nt_pkg::st_idle:
				if (i_engine_en)
					state_d = ddr_nt_pkg::st_cmd_pre;
			ddr_nt_pkg::st_cmd_pre:
				if (i_lane.tx_done)
					state_d = ddr_nt_pkg::st_rw_bit;
			ddr_nt_pkg::st_rw_bit:
				if (i_lane.tx_done)
					state_d = ddr_nt_pkg::st_seven_zeros;
			ddr_nt_pkg::st_seven_zeros:
				if (i_lane.tx_done)
					state_d = ddr_nt_pkg::st_address;
			ddr_nt_pkg::st_address:
				if (i_lane.tx_done)
					state_d = ddr_nt_pkg::st_parity;
			ddr_nt_pkg::st_parity:
				if (step)
				begin
					if (!o_data_phase)
						state_d = ddr_nt_pkg::st_ack_pre;	// command word done
					else if (!i_cfg.rnw)
						state_d = i_lane.frm_last ? ddr_nt_pkg::st_crc_pre_1
							: ddr_nt_pkg::st_data_pre;
					else if (i_lane.rx_error)
						state_d = ddr_nt_pkg::st_error;	// target parity mismatch
					else
						state_d = ddr_nt_pkg::st_data_pre;
				end
			ddr_nt_pkg::st_ack_pre:
				if (i_lane.tx_done)
					state_d = ddr_nt_pkg::st_ack_wait;
			ddr_nt_pkg::st_ack_wait:
				if (o_ack_ready && i_lane.rx_done)
					state_d = i_lane.rx_pre ? ddr_nt_pkg::st_error	// nack
						: ddr_nt_pkg::st_data_byte_1;
			ddr_nt_pkg::st_data_byte_1:
				if (step)
					state_d = i_lane.frm_last ? ddr_nt_pkg::st_dummy_byte
						: ddr_nt_pkg::st_data_byte_2;
			ddr_nt_pkg::st_data_byte_2, ddr_nt_pkg::st_dummy_byte:
				if (step)
					state_d = ddr_nt_pkg::st_parity;
			ddr_nt_pkg::st_data_pre:
				if (step)
				begin
					if (!i_cfg.rnw)
						state_d = ddr_nt_pkg::st_abort_bit;	// target may still stop us
					else if (i_lane.rx_pre)
						state_d = ddr_nt_pkg::st_abort_bit;	// target has more data
					else if (!i_lane.frm_last && i_cfg.short_read_err)
						state_d = ddr_nt_pkg::st_error;	// ended early
					else
						state_d = ddr_nt_pkg::st_crc_pre_2;
				end
			ddr_nt_pkg::st_abort_bit:
				if (step)
				begin
					if (!i_cfg.rnw)
						state_d = i_lane.rx_pre ? ddr_nt_pkg::st_data_byte_1
							: ddr_nt_pkg::st_error;
					else
						state_d = i_lane.frm_last ? ddr_nt_pkg::st_error
							: ddr_nt_pkg::st_data_byte_1;
				end
			ddr_nt_pkg::st_crc_pre_1:
				if (step)
					state_d = ddr_nt_pkg::st_crc_pre_2;
			ddr_nt_pkg::st_crc_pre_2:
				if (step)
					state_d = (i_cfg.rnw && !i_lane.rx_pre) ? ddr_nt_pkg::st_error
						: ddr_nt_pkg::st_crc_token;
			ddr_nt_pkg::st_crc_token:
				if (step)
					state_d = (i_cfg.rnw && i_lane.rx_error) ? ddr_nt_pkg::st_error
						: ddr_nt_pkg::st_crc_value;
			ddr_nt_pkg::st_crc_value:
				if (step)
				begin
					if (i_cfg.rnw && i_lane.rx_error)
						state_d = ddr_nt_pkg::st_error;	// crc mismatch
					else
						state_d = i_cfg.toc ? ddr_nt_pkg::st_exit : ddr_nt_pkg::st_restart;
				end
			ddr_nt_pkg::st_error:
				if (i_lane.rx_done)
					state_d = i_cfg.toc ? ddr_nt_pkg::st_exit : ddr_nt_pkg::st_restart;
			ddr_nt_pkg::st_restart, ddr_nt_pkg::st_exit:
				if (i_lane.tx_done)
					state_d = ddr_nt_pkg::st_idle;
			default:
				state_d = ddr_nt_pkg::st_idle;
		endcase
	end

	// the branch decision lane_ctrl turns into an error code
	assign o_err_branch = (state_d == ddr_nt_pkg::st_error) && (state_q != ddr_nt_pkg::st_error);

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			o_data_phase  <= 1'b0;
			o_ack_ready   <= 1'b0;
			o_engine_done <= 1'b0;
		end
		else
		begin
			if (state_q == ddr_nt_pkg::st_idle)
				o_data_phase <= 1'b0;	// next parity is the command one
			else if (state_q == ddr_nt_pkg::st_data_byte_1
				|| state_q == ddr_nt_pkg::st_data_byte_2
				|| state_q == ddr_nt_pkg::st_dummy_byte)
				o_data_phase <= 1'b1;
			o_ack_ready <= (state_q == ddr_nt_pkg::st_ack_wait);	// low on the entry cycle
			// pulse on the edge that returns to idle
			o_engine_done <= (state_q == ddr_nt_pkg::st_restart
				|| state_q == ddr_nt_pkg::st_exit) && i_lane.tx_done;
		end
	end

	assign o_state = state_q;

endmodule

`default_nettype wire

/* ddr_nt_pkg.sv */
`default_nettype none

package ddr_nt_pkg;

	localparam int ADDR_W = 12;	// register file address width

	// frame states of one hdr-ddr normal transfer
	typedef enum logic [4:0] {
		st_idle,
		st_cmd_pre,	// special command preamble
		st_rw_bit,
		st_seven_zeros,
		st_address,	// dynamic address of the target
		st_parity,	// shared by command word and data words
		st_ack_pre,	// controller one preamble ahead of the ack
		st_ack_wait,
		st_data_byte_1,
		st_data_byte_2,
		st_dummy_byte,	// pads an odd byte count
		st_data_pre,
		st_abort_bit,
		st_crc_pre_1,
		st_crc_pre_2,
		st_crc_token,
		st_crc_value,
		st_error,
		st_restart,
		st_exit
	} nt_state_e;

	// serializer modes, bit patterns decoded by the tx lane
	typedef enum logic [3:0] {
		txm_special_pre = 4'b0000,
		txm_address     = 4'b0001,
		txm_one_pre     = 4'b0010,
		txm_seven_zeros = 4'b0011,
		txm_parity      = 4'b0100,
		txm_zero_pre    = 4'b0110,
		txm_byte        = 4'b0111,
		txm_token_crc   = 4'b1100,
		txm_crc_value   = 4'b1101,
		txm_exit        = 4'b1110,
		txm_restart     = 4'b1111
	} tx_mode_e;

	// deserializer modes
	typedef enum logic [3:0] {
		rxm_preamble     = 4'd0,
		rxm_byte         = 4'd3,
		rxm_check_token  = 4'd4,
		rxm_check_parity = 4'd5,
		rxm_check_crc    = 4'd6,
		rxm_error        = 4'd7	// wait for the bus to settle after a fault
	} rx_mode_e;

	typedef enum logic [3:0] {
		err_success     = 4'd0,
		err_crc         = 4'd1,
		err_parity      = 4'd2,
		err_frame       = 4'd3,
		err_addr_header = 4'd4,
		err_nack        = 4'd5,
		err_ovl         = 4'd6,
		err_short_read  = 4'd7,
		err_hc_aborted  = 4'd8,
		err_bus_aborted = 4'd9
	} err_type_e;

	typedef struct packed {
		logic       toc;	// 0 restart, 1 exit
		logic [4:0] dev_index;
		logic       short_read_err;
		logic       rnw;	// 1 read
		logic       immediate;	// bit 0 of the command attribute
		logic       wroc;
	} xfer_cfg_t;

	typedef struct packed {
		logic tx_done;	// one-cycle pulses
		logic rx_done;
		logic rx_pre;	// sampled preamble bit
		logic rx_error;
		logic frm_last;	// frame counter on its last word
	} lane_stat_t;

	typedef struct packed {
		logic       tx_en;
		tx_mode_e   tx_mode;
		logic       rx_en;
		rx_mode_e   rx_mode;
		logic [7:0] special_data;
	} lane_cmd_t;

	typedef struct packed {
		logic       en;
		logic [4:0] cycles;
	} stall_req_t;

endpackage

`default_nettype wire
